// ==== Bender.yml ====
package:
  name: queue_memory

sources:
  - rtl/queue_mem_pkg.sv
  - rtl/enqueue_writer.sv
  - rtl/head_pointer_table.sv
  - rtl/queue_word_ram.sv
  - rtl/dequeue_formatter.sv
  - rtl/queue_memory_top.sv
  - target: simulation
    files:
      - bench/queue_memory_clock.sv
      - bench/queue_memory_tb.sv

// ==== bench/queue_memory_clock.sv ====
////////////////////
// 20 ns clock from time zero; reset held low for the first 3 rising edges
////////////////////

`timescale 1ns/1ps
`default_nettype none

module queue_memory_clock #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 3
) (
    output logic packet_in,
    output logic rst_n
);

    initial begin
        packet_in = 1'b0;
        forever begin
            #(period_ns / 2) packet_in = ~packet_in;
        end
    end

    // Released on a rising edge, like every other DUT input
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge packet_in);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/queue_memory_tb.sv ====
////////////////////
// Directed tests with default DUT parameters. Each word is dequeued at least
// 3 cycles after its enqueue, since the word RAM has no bypass.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module queue_memory_tb;

    localparam int words_per_page  = 4;
    // Tests run about 130 cycles after reset
    localparam int max_cycles      = 400;

    typedef struct packed {
        logic [31:0]                            due;
        logic [queue_mem_pkg::data_bytes*8-1:0] data;
        logic [queue_mem_pkg::data_bytes-1:0]   keep;
        logic                                   last;
        logic [queue_mem_pkg::queue_w-1:0]      queue;
    } exp_word_t;

    typedef struct packed {
        logic [31:0]                      due;
        logic [queue_mem_pkg::page_w-1:0] page;
    } exp_free_t;

    logic                      packet_in;
    logic                      rst_n;
    queue_mem_pkg::enq_word_t  enq;
    queue_mem_pkg::deq_req_t   deq_req;
    queue_mem_pkg::head_load_t head_load;
    queue_mem_pkg::word_out_t  word_out;
    queue_mem_pkg::deq_note_t  deq_note;
    queue_mem_pkg::page_free_t page_free;

    exp_word_t exp_words [$];
    exp_free_t exp_frees [$];
    int        cycle          = 0;
    int        mismatch_count = 0;
    int        failure_count  = 0;
    integer    seed           = 32'h9471b3ba;

    queue_memory_clock i_queue_memory_clock (
        .packet_in (packet_in),
        .rst_n     (rst_n)
    );

    queue_memory_top i_queue_memory_top (
        .packet_in (packet_in),
        .rst_n     (rst_n),
        .enq       (enq),
        .deq_req   (deq_req),
        .head_load (head_load),
        .word_out  (word_out),
        .deq_note  (deq_note),
        .page_free (page_free)
    );

    always @(posedge packet_in) begin
        cycle <= cycle + 1;
    end

    ////////////////////
    // Reporting

    task automatic flag_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] expected);
        $display("MISMATCH at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, expected);
        mismatch_count++;
    endtask

    task automatic flag_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        failure_count++;
    endtask

    task automatic print_counts;
        $display("Error counts: %0d mismatches, %0d other failures",
                 mismatch_count, failure_count);
    endtask

    ////////////////////
    // Output monitor

    // Word and notice fields against the expected entry
    task automatic compare_word(input exp_word_t ew);
        logic [queue_mem_pkg::port_w-1:0] exp_port;
        logic [3:0]                       exp_bytes;
        // Queues 0 to 3 use port 0, queues 4 to 7 port 1
        exp_port  = (ew.queue < 3'd4) ? 1'b0 : 1'b1;
        exp_bytes = 4'($countones(ew.keep));
        if (cycle != int'(ew.due)) begin
            flag_mismatch("word_out arrival cycle", 64'(cycle), 64'(ew.due));
        end
        if (word_out.data !== ew.data) begin
            flag_mismatch("word_out.data", word_out.data, ew.data);
        end
        if (word_out.keep !== ew.keep) begin
            flag_mismatch("word_out.keep", 64'(word_out.keep), 64'(ew.keep));
        end
        if (word_out.last !== ew.last) begin
            flag_mismatch("word_out.last", 64'(word_out.last), 64'(ew.last));
        end
        if (word_out.egress_port !== exp_port) begin
            flag_mismatch("word_out.egress_port", 64'(word_out.egress_port), 64'(exp_port));
        end
        if (deq_note.valid_bytes !== exp_bytes) begin
            flag_mismatch("deq_note.valid_bytes", 64'(deq_note.valid_bytes), 64'(exp_bytes));
        end
        if (deq_note.last !== ew.last) begin
            flag_mismatch("deq_note.last", 64'(deq_note.last), 64'(ew.last));
        end
        if (deq_note.queue !== ew.queue) begin
            flag_mismatch("deq_note.queue", 64'(deq_note.queue), 64'(ew.queue));
        end
    endtask

    // Falling edge, where all DUT outputs are settled
    always @(negedge packet_in) begin : output_monitor
        exp_word_t ew;
        exp_free_t ef;
        if (rst_n === 1'b1) begin
            if (word_out.valid === 1'b1) begin
                if (exp_words.size() == 0) begin
                    flag_failure("word_out went valid with no dequeue outstanding");
                end else begin
                    ew = exp_words.pop_front();
                    compare_word(ew);
                end
            end else if (exp_words.size() != 0) begin
                ew = exp_words[0];
                if (cycle >= int'(ew.due)) begin
                    ew = exp_words.pop_front();
                    flag_failure($sformatf("word_out for queue %0d not valid in cycle %0d",
                                           ew.queue, ew.due));
                end
            end
            if (deq_note.valid !== word_out.valid) begin
                flag_failure("deq_note valid does not follow word_out valid");
            end
            if (page_free.valid === 1'b1) begin
                if (exp_frees.size() == 0) begin
                    flag_failure("page_free went valid with no page end read");
                end else begin
                    ef = exp_frees.pop_front();
                    if (cycle != int'(ef.due)) begin
                        flag_mismatch("page_free arrival cycle", 64'(cycle), 64'(ef.due));
                    end
                    if (page_free.page !== ef.page) begin
                        flag_mismatch("page_free.page", 64'(page_free.page), 64'(ef.page));
                    end
                end
            end else if (exp_frees.size() != 0) begin
                ef = exp_frees[0];
                if (cycle >= int'(ef.due)) begin
                    ef = exp_frees.pop_front();
                    flag_failure($sformatf("page_free for page %0d not valid in cycle %0d",
                                           ef.page, ef.due));
                end
            end
        end
    end

    ////////////////////
    // Stimulus helpers

    function automatic logic [63:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic idle(input int n);
        repeat (n) @(posedge packet_in);
    endtask

    task automatic load_head(input logic [2:0] queue, input logic [3:0] page,
                             input logic [1:0] offset);
        @(posedge packet_in);
        head_load <= '{1'b1, queue, page, offset};
        @(posedge packet_in);
        head_load.valid <= 1'b0;
    endtask

    // Sop fields matter on the first word of a packet only
    task automatic send_word(input logic [63:0] data, input logic [7:0] keep,
                             input logic last, input logic [3:0] page,
                             input logic [3:0] next_page, input logic [1:0] tail);
        @(posedge packet_in);
        enq <= '{1'b1, data, keep, last, page, next_page, tail};
    endtask

    task automatic request_dequeue(input logic [2:0] queue, input logic [63:0] data,
                                   input logic [7:0] keep, input logic last,
                                   input logic frees, input logic [3:0] free_page);
        int        t;
        exp_word_t ew;
        exp_free_t ef;
        @(posedge packet_in);
        // Cycle that this edge opens
        t = cycle + 1;
        deq_req <= '{1'b1, queue};
        ew = '{32'(t + 4), data, keep, last, queue};
        exp_words.push_back(ew);
        if (frees) begin
            ef = '{32'(t + 1), free_page};
            exp_frees.push_back(ef);
        end
    endtask

    task automatic release_inputs;
        @(posedge packet_in);
        enq.valid     <= 1'b0;
        deq_req.valid <= 1'b0;
    endtask

    task automatic wait_drained;
        while (exp_words.size() != 0 || exp_frees.size() != 0) begin
            @(posedge packet_in);
        end
        idle(3);
    endtask

    ////////////////////
    // Tests

    task automatic check_idle_after_reset;
        repeat (8) begin
            @(negedge packet_in);
            if (word_out.valid !== 1'b0 || deq_note.valid !== 1'b0 ||
                page_free.valid !== 1'b0) begin
                flag_failure("an output is valid after reset with no request made");
            end
        end
    endtask

    task automatic check_full_word_packet;
        logic [63:0] words [3];
        for (int i = 0; i < 3; i++) begin
            words[i] = random_word();
        end
        load_head(3'd1, 4'd2, 2'd0);
        for (int i = 0; i < 3; i++) begin
            send_word(words[i], 8'hff, i == 2, 4'd2, 4'd15, 2'd0);
        end
        release_inputs();
        idle(2);
        for (int i = 0; i < 3; i++) begin
            request_dequeue(3'd1, words[i], 8'hff, i == 2, 1'b0, 4'd0);
        end
        release_inputs();
        wait_drained();
    endtask

    task automatic check_partial_last_word;
        logic [63:0] words [2];
        words[0] = random_word();
        words[1] = random_word();
        load_head(3'd2, 4'd4, 2'd0);
        send_word(words[0], 8'hff, 1'b0, 4'd4, 4'd14, 2'd0);
        // Five valid bytes
        send_word(words[1], 8'h1f, 1'b1, 4'd4, 4'd14, 2'd0);
        release_inputs();
        idle(2);
        request_dequeue(3'd2, words[0], 8'hff, 1'b0, 1'b0, 4'd0);
        request_dequeue(3'd2, words[1], 8'h1f, 1'b1, 1'b0, 4'd0);
        release_inputs();
        wait_drained();
    endtask

    task automatic check_page_crossing;
        logic [63:0] words [6];
        int          pos;
        for (int i = 0; i < 6; i++) begin
            words[i] = random_word();
        end
        load_head(3'd3, 4'd3, 2'd2);
        for (int i = 0; i < 6; i++) begin
            send_word(words[i], 8'hff, i == 5, 4'd3, 4'd7, 2'd2);
        end
        release_inputs();
        idle(2);
        for (int i = 0; i < 6; i++) begin
            // Word position counted from the start of page 3
            pos = 2 + i;
            request_dequeue(3'd3, words[i], 8'hff, i == 5,
                            (pos % words_per_page) == words_per_page - 1,
                            (pos < words_per_page) ? 4'd3 : 4'd7);
        end
        release_inputs();
        wait_drained();
    endtask

    task automatic check_queue_ports;
        logic [63:0] words_a [3];
        logic [63:0] words_b [3];
        for (int i = 0; i < 3; i++) begin
            words_a[i] = random_word();
            words_b[i] = random_word();
        end
        load_head(3'd1, 4'd9, 2'd0);
        load_head(3'd6, 4'd10, 2'd0);
        for (int i = 0; i < 3; i++) begin
            send_word(words_a[i], 8'hff, i == 2, 4'd9, 4'd11, 2'd0);
        end
        for (int i = 0; i < 3; i++) begin
            send_word(words_b[i], (i == 2) ? 8'h03 : 8'hff, i == 2, 4'd10, 4'd12, 2'd0);
        end
        release_inputs();
        idle(2);
        // Alternate queues on every cycle
        for (int i = 0; i < 3; i++) begin
            request_dequeue(3'd1, words_a[i], 8'hff, i == 2, 1'b0, 4'd0);
            request_dequeue(3'd6, words_b[i], (i == 2) ? 8'h03 : 8'hff, i == 2, 1'b0, 4'd0);
        end
        release_inputs();
        wait_drained();
    endtask

    ////////////////////
    // Run control

    initial begin : main
        enq       = '0;
        deq_req   = '0;
        head_load = '0;
        wait (rst_n === 1'b1);
        @(posedge packet_in);
        check_idle_after_reset();
        check_full_word_packet();
        check_partial_last_word();
        check_page_crossing();
        check_queue_ports();
        print_counts();
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        wait (cycle >= max_cycles);
        $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
        print_counts();
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/queue_mem_pkg.sv
rtl/enqueue_writer.sv
rtl/head_pointer_table.sv
rtl/queue_word_ram.sv
rtl/dequeue_formatter.sv
rtl/queue_memory_top.sv
bench/queue_memory_clock.sv
bench/queue_memory_tb.sv

// ==== rtl/dequeue_formatter.sv ====
////////////////////
// Egress port is the queue id divided by queues_per_port
////////////////////

`timescale 1ns/1ps
`default_nettype none

module dequeue_formatter #(
    parameter int queues_per_port = 4
) (
    input  logic                                   packet_in,
    input  logic                                   rst_n,
    input  logic                                   rd_valid,
    input  logic [queue_mem_pkg::data_bytes*8-1:0] rd_data,
    input  queue_mem_pkg::blen_entry_t             rd_blen,
    input  logic [queue_mem_pkg::queue_w-1:0]      rd_queue,
    output queue_mem_pkg::word_out_t               word_out,
    output queue_mem_pkg::deq_note_t               deq_note
);

    logic [queue_mem_pkg::port_w-1:0]       egress_port;
    logic [queue_mem_pkg::data_bytes-1:0]   keep;
    logic [queue_mem_pkg::data_bytes_log:0] valid_bytes;

    assign egress_port = queue_mem_pkg::port_w'(rd_queue / queues_per_port);
    assign keep        = queue_mem_pkg::decode_keep(rd_blen.keep_encoded);
    assign valid_bytes = queue_mem_pkg::valid_bytes_of(rd_blen.keep_encoded);

    ////////////////////
    // Output registers

    always_ff @(posedge packet_in) begin
        word_out.data        <= rd_data;
        word_out.keep        <= keep;
        word_out.last        <= rd_blen.last;
        word_out.egress_port <= egress_port;

        deq_note.valid_bytes <= valid_bytes;
        deq_note.last        <= rd_blen.last;
        deq_note.queue       <= rd_queue;

        if (!rst_n) begin
            word_out.valid <= 1'b0;
            deq_note.valid <= 1'b0;
        end else begin
            // Word and notice leave together
            word_out.valid <= rd_valid;
            deq_note.valid <= rd_valid;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/enqueue_writer.sv ====
////////////////////
// A packet may span at most two pages: only one next page is held per packet.
// No back-pressure, every valid word is written.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module enqueue_writer #(
    parameter int words_per_page = 4,
    parameter int num_pages      = 16
) (
    input  logic                                      packet_in,
    input  logic                                      rst_n,
    input  queue_mem_pkg::enq_word_t                  enq,
    output logic                                      wr_valid,
    output logic [queue_mem_pkg::addr_w-1:0]          wr_addr,
    output logic [queue_mem_pkg::data_bytes*8-1:0]    wr_data,
    output queue_mem_pkg::blen_entry_t                wr_blen,
    output queue_mem_pkg::page_link_t                 wr_link
);

    localparam logic [queue_mem_pkg::offset_w-1:0] last_off =
        queue_mem_pkg::offset_w'(words_per_page - 1);

    logic                                sop;
    logic [queue_mem_pkg::page_w-1:0]    cur_page;
    logic [queue_mem_pkg::page_w-1:0]    next_page;
    logic [queue_mem_pkg::offset_w-1:0]  tail;

    // Position of the word on the input this cycle
    logic [queue_mem_pkg::page_w-1:0]    word_page;
    logic [queue_mem_pkg::page_w-1:0]    word_next;
    logic [queue_mem_pkg::offset_w-1:0]  word_off;

    assign word_page = sop ? enq.sop_page      : cur_page;
    assign word_next = sop ? enq.sop_next_page : next_page;
    assign word_off  = sop ? enq.sop_tail      : tail;

    ////////////////////
    // Address generation

    always_ff @(posedge packet_in) begin
        if (enq.valid) begin
            if (sop) begin
                next_page <= enq.sop_next_page;
            end
            if (word_off == last_off) begin
                cur_page <= word_next;
                tail     <= '0;
            end else begin
                cur_page <= word_page;
                tail     <= word_off + 1'b1;
            end
        end
    end

    ////////////////////
    // Write command and page link

    always_ff @(posedge packet_in) begin
        wr_data              <= enq.data;
        wr_blen.keep_encoded <= queue_mem_pkg::encode_keep(enq.keep);
        wr_blen.last         <= enq.last;
        wr_addr              <= queue_mem_pkg::page_addr(word_page, word_off, words_per_page);
        wr_link.from_page    <= word_page;
        wr_link.to_page      <= word_next;

        if (!rst_n) begin
            sop           <= 1'b1;
            wr_valid      <= 1'b0;
            wr_link.valid <= 1'b0;
        end else begin
            wr_valid <= enq.valid;
            // Queue continues on the next page even if the packet ends here
            wr_link.valid <= enq.valid && (word_off == last_off);
            if (enq.valid) begin
                sop <= enq.last;
            end
        end
    end

    // First word must name a page that exists
    a_sop_page_range : assert property (
        @(posedge packet_in) disable iff (!rst_n)
        (enq.valid && sop) |-> (int'(enq.sop_page) < num_pages)
    );

endmodule

`default_nettype wire

// ==== rtl/head_pointer_table.sv ====
////////////////////
// A queue must be loaded before its first dequeue. A load wins over a
// same-cycle dequeue of that queue.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module head_pointer_table #(
    parameter int words_per_page = 4,
    parameter int num_pages      = 16,
    parameter int num_queues     = 8
) (
    input  logic                        packet_in,
    input  logic                        rst_n,
    input  queue_mem_pkg::head_load_t   head_load,
    input  queue_mem_pkg::deq_req_t     deq_req,
    input  queue_mem_pkg::page_link_t   wr_link,
    output queue_mem_pkg::rd_cmd_t      rd_cmd,
    output queue_mem_pkg::page_free_t   page_free
);

    localparam logic [queue_mem_pkg::offset_w-1:0] last_off =
        queue_mem_pkg::offset_w'(words_per_page - 1);

    // Per-queue head
    logic [queue_mem_pkg::page_w-1:0]   head_page   [num_queues];
    logic [queue_mem_pkg::offset_w-1:0] head_offset [num_queues];
    logic [num_queues-1:0]              loaded;

    // Page links recorded by the writer
    logic [queue_mem_pkg::page_w-1:0]   link_next   [num_pages];

    logic [queue_mem_pkg::page_w-1:0]   req_page;
    logic [queue_mem_pkg::offset_w-1:0] req_off;
    logic                               req_page_end;

    assign req_page     = head_page[deq_req.queue];
    assign req_off      = head_offset[deq_req.queue];
    assign req_page_end = (req_off == last_off);

    always_ff @(posedge packet_in) begin
        if (wr_link.valid) begin
            link_next[wr_link.from_page] <= wr_link.to_page;
        end
    end

    ////////////////////
    // Head update

    always_ff @(posedge packet_in) begin
        if (deq_req.valid) begin
            if (req_page_end) begin
                head_offset[deq_req.queue] <= '0;
                head_page[deq_req.queue]   <= link_next[req_page];
            end else begin
                head_offset[deq_req.queue] <= req_off + 1'b1;
            end
        end
        if (head_load.valid) begin
            head_page[head_load.queue]   <= head_load.page;
            head_offset[head_load.queue] <= head_load.offset;
        end

        if (!rst_n) begin
            loaded <= '0;
        end else if (head_load.valid) begin
            loaded[head_load.queue] <= 1'b1;
        end
    end

    ////////////////////
    // Read command and page free

    always_ff @(posedge packet_in) begin
        rd_cmd.address <= queue_mem_pkg::page_addr(req_page, req_off, words_per_page);
        rd_cmd.queue   <= deq_req.queue;
        page_free.page <= req_page;

        if (!rst_n) begin
            rd_cmd.valid    <= 1'b0;
            page_free.valid <= 1'b0;
        end else begin
            rd_cmd.valid    <= deq_req.valid;
            page_free.valid <= deq_req.valid && req_page_end;
        end
    end

    a_deq_loaded : assert property (
        @(posedge packet_in) disable iff (!rst_n)
        deq_req.valid |-> loaded[deq_req.queue]
    );

endmodule

`default_nettype wire

// ==== rtl/queue_mem_pkg.sv ====
////////////////////
// Widths, stream structs and keep coding shared by the queue memory blocks.
// Keep must never be all zero; the encoding has no code for it.
////////////////////

`default_nettype none

package queue_mem_pkg;

    ////////////////////
    // Widths

    localparam int data_bytes     = 8;
    localparam int data_bytes_log = 3;
    localparam int page_w         = 4;
    localparam int offset_w       = 2;
    localparam int queue_w        = 3;
    localparam int port_w         = 1;
    localparam int addr_w         = page_w + offset_w;

    ////////////////////
    // Stream structs

    typedef struct packed {
        logic                    valid;
        logic [data_bytes*8-1:0] data;
        logic [data_bytes-1:0]   keep;
        logic                    last;
        // Sampled on the first word of a packet only
        logic [page_w-1:0]       sop_page;
        logic [page_w-1:0]       sop_next_page;
        logic [offset_w-1:0]     sop_tail;
    } enq_word_t;

    typedef struct packed {
        logic               valid;
        logic [queue_w-1:0] queue;
    } deq_req_t;

    typedef struct packed {
        logic                valid;
        logic [queue_w-1:0]  queue;
        logic [page_w-1:0]   page;
        logic [offset_w-1:0] offset;
    } head_load_t;

    typedef struct packed {
        logic [data_bytes_log-1:0] keep_encoded;
        logic                      last;
    } blen_entry_t;

    typedef struct packed {
        logic                    valid;
        logic [data_bytes*8-1:0] data;
        logic [data_bytes-1:0]   keep;
        logic                    last;
        logic [port_w-1:0]       egress_port;
    } word_out_t;

    typedef struct packed {
        logic                    valid;
        logic [data_bytes_log:0] valid_bytes;
        logic                    last;
        logic [queue_w-1:0]      queue;
    } deq_note_t;

    typedef struct packed {
        logic              valid;
        logic [page_w-1:0] page;
    } page_free_t;

    typedef struct packed {
        logic               valid;
        logic [addr_w-1:0]  address;
        logic [queue_w-1:0] queue;
    } rd_cmd_t;

    typedef struct packed {
        logic              valid;
        logic [page_w-1:0] from_page;
        logic [page_w-1:0] to_page;
    } page_link_t;

    ////////////////////
    // Functions

    // Word address of a page and offset, page in the upper part
    function automatic logic [addr_w-1:0] page_addr(
        input logic [page_w-1:0]   page,
        input logic [offset_w-1:0] offset,
        input int                  words_per_page
    );
        return addr_w'(page * words_per_page + offset);
    endfunction

    // All ones maps to 0, otherwise the count of valid low bytes
    function automatic logic [data_bytes_log-1:0] encode_keep(
        input logic [data_bytes-1:0] keep
    );
        for (int i = 1; i < data_bytes; i++) begin
            if (!keep[i]) begin
                return data_bytes_log'(i);
            end
        end
        return '0;
    endfunction

    function automatic logic [data_bytes-1:0] decode_keep(
        input logic [data_bytes_log-1:0] keep_encoded
    );
        logic [data_bytes-1:0] keep;
        keep = '0;
        if (keep_encoded == '0) begin
            return '1;
        end
        for (int i = 0; i < data_bytes; i++) begin
            if (i < keep_encoded) begin
                keep[i] = 1'b1;
            end
        end
        return keep;
    endfunction

    function automatic logic [data_bytes_log:0] valid_bytes_of(
        input logic [data_bytes_log-1:0] keep_encoded
    );
        return (keep_encoded == '0) ? (data_bytes_log+1)'(data_bytes) : {1'b0, keep_encoded};
    endfunction

endpackage

`default_nettype wire

// ==== rtl/queue_memory_top.sv ====
////////////////////
// Valid-only streams with no back-pressure. Dequeue output lags the request
// by 4 cycles, page free by 1.
////////////////////

`timescale 1ns/1ps
`default_nettype none

module queue_memory_top #(
    parameter int words_per_page  = 4,
    parameter int num_pages       = 16,
    parameter int num_queues      = 8,
    parameter int queues_per_port = 4
) (
    input  logic                        packet_in,
    input  logic                        rst_n,
    input  queue_mem_pkg::enq_word_t    enq,
    input  queue_mem_pkg::deq_req_t     deq_req,
    input  queue_mem_pkg::head_load_t   head_load,
    output queue_mem_pkg::word_out_t    word_out,
    output queue_mem_pkg::deq_note_t    deq_note,
    output queue_mem_pkg::page_free_t   page_free
);

    // Write side
    logic                                   wr_valid;
    logic [queue_mem_pkg::addr_w-1:0]       wr_addr;
    logic [queue_mem_pkg::data_bytes*8-1:0] wr_data;
    queue_mem_pkg::blen_entry_t             wr_blen;
    queue_mem_pkg::page_link_t              wr_link;

    // Read side
    queue_mem_pkg::rd_cmd_t                 rd_cmd;
    logic                                   rd_valid;
    logic [queue_mem_pkg::data_bytes*8-1:0] rd_data;
    queue_mem_pkg::blen_entry_t             rd_blen;
    logic [queue_mem_pkg::queue_w-1:0]      rd_queue;

    enqueue_writer #(
        .words_per_page (words_per_page),
        .num_pages      (num_pages)
    ) i_enqueue_writer (
        .packet_in (packet_in),
        .rst_n     (rst_n),
        .enq       (enq),
        .wr_valid  (wr_valid),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_blen   (wr_blen),
        .wr_link   (wr_link)
    );

    // Decode stage
    head_pointer_table #(
        .words_per_page (words_per_page),
        .num_pages      (num_pages),
        .num_queues     (num_queues)
    ) i_head_pointer_table (
        .packet_in (packet_in),
        .rst_n     (rst_n),
        .head_load (head_load),
        .deq_req   (deq_req),
        .wr_link   (wr_link),
        .rd_cmd    (rd_cmd),
        .page_free (page_free)
    );

    // Execute stage
    queue_word_ram #(
        .depth (num_pages * words_per_page)
    ) i_queue_word_ram (
        .packet_in (packet_in),
        .rst_n     (rst_n),
        .wr_valid  (wr_valid),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_blen   (wr_blen),
        .rd_cmd    (rd_cmd),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_blen   (rd_blen),
        .rd_queue  (rd_queue)
    );

    // Result stage
    dequeue_formatter #(
        .queues_per_port (queues_per_port)
    ) i_dequeue_formatter (
        .packet_in (packet_in),
        .rst_n     (rst_n),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_blen   (rd_blen),
        .rd_queue  (rd_queue),
        .word_out  (word_out),
        .deq_note  (deq_note)
    );

endmodule

`default_nettype wire

// ==== rtl/queue_word_ram.sv ====
////////////////////
// No read-after-write bypass; read a word 3 or more cycles after enqueue
////////////////////

`timescale 1ns/1ps
`default_nettype none

module queue_word_ram #(
    parameter int depth = 64
) (
    input  logic                                   packet_in,
    input  logic                                   rst_n,
    input  logic                                   wr_valid,
    input  logic [queue_mem_pkg::addr_w-1:0]       wr_addr,
    input  logic [queue_mem_pkg::data_bytes*8-1:0] wr_data,
    input  queue_mem_pkg::blen_entry_t             wr_blen,
    input  queue_mem_pkg::rd_cmd_t                 rd_cmd,
    output logic                                   rd_valid,
    output logic [queue_mem_pkg::data_bytes*8-1:0] rd_data,
    output queue_mem_pkg::blen_entry_t             rd_blen,
    output logic [queue_mem_pkg::queue_w-1:0]      rd_queue
);

    logic [queue_mem_pkg::data_bytes*8-1:0] word_mem [depth];
    queue_mem_pkg::blen_entry_t             blen_mem [depth];

    // First read register
    logic [queue_mem_pkg::data_bytes*8-1:0] data_q1;
    queue_mem_pkg::blen_entry_t             blen_q1;
    logic                                   valid_q1;
    logic [queue_mem_pkg::queue_w-1:0]      queue_q1;

    always_ff @(posedge packet_in) begin
        if (wr_valid) begin
            word_mem[wr_addr] <= wr_data;
            blen_mem[wr_addr] <= wr_blen;
        end
    end

    ////////////////////
    // Two-stage read

    always_ff @(posedge packet_in) begin
        data_q1  <= word_mem[rd_cmd.address];
        blen_q1  <= blen_mem[rd_cmd.address];
        queue_q1 <= rd_cmd.queue;
        rd_data  <= data_q1;
        rd_blen  <= blen_q1;
        rd_queue <= queue_q1;

        if (!rst_n) begin
            valid_q1 <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            valid_q1 <= rd_cmd.valid;
            rd_valid <= valid_q1;
        end
    end

    // Dequeue must not reach a word still being written
    a_no_rw_collision : assert property (
        @(posedge packet_in) disable iff (!rst_n)
        (wr_valid && rd_cmd.valid) |-> (wr_addr != rd_cmd.address)
    );

endmodule

`default_nettype wire
